// ==== verilog/mesh_cfg.svh ====
`ifndef MESH_CFG_SVH
`define MESH_CFG_SVH

// Square matrix dimension (N x N)
`define MS_MATRIX_SIZE 4

// Tile dimension (T x T), must divide the matrix size
`define MS_TILE_SIZE 2

// Width of one A or B element
`define MS_DATA_WIDTH 16

// Width of one C accumulator entry
// Holds N products of two full-width elements with headroom
`define MS_ACC_WIDTH 40

`endif

// ==== verilog/mesh_pkg.sv ====
`include "mesh_cfg.svh"

package mesh_pkg;

    // Sizes taken from the configuration header
    localparam int MS_N = `MS_MATRIX_SIZE;
    localparam int MS_T = `MS_TILE_SIZE;

    // Tiles per side, store depth and total pair count
    localparam int MS_TILES    = MS_N / MS_T;
    localparam int MS_DEPTH    = MS_N * MS_N;
    localparam int MS_ADDR_W   = $clog2(MS_DEPTH);
    localparam int MS_PRODUCTS = MS_N * MS_N * MS_N;

    // Index widths, kept at least one bit wide
    localparam int MS_TILE_IDX_W = (MS_TILES > 1) ? $clog2(MS_TILES) : 1;
    localparam int MS_ELEM_IDX_W = (MS_T > 1) ? $clog2(MS_T) : 1;

    typedef logic [`MS_DATA_WIDTH-1:0] elem_t;
    typedef logic [`MS_ACC_WIDTH-1:0]  acc_t;
    typedef logic [MS_ADDR_W-1:0]      addr_t;
    typedef logic [MS_TILE_IDX_W-1:0]  tile_idx_t;
    typedef logic [MS_ELEM_IDX_W-1:0]  elem_idx_t;

    // One row-major write into a matrix store
    typedef struct packed {
        logic  en;
        elem_t data;
    } wr_port_t;

    // Travels next to the store read data, one per operand pair
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  last;
        addr_t c_addr;
    } pair_meta_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

// ==== verilog/matrix_store.sv ====
`timescale 1ns/1ps

module matrix_store (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               clear_i,
    input  mesh_pkg::wr_port_t wr_i,
    input  logic               rd_en_i,
    input  mesh_pkg::addr_t    rd_addr_i,
    output mesh_pkg::elem_t    rd_data_o,
    output logic               full_o
);

    import mesh_pkg::*;

    elem_t mem_q [MS_DEPTH];

    addr_t fill_ptr_q;
    logic  full_q;
    logic  wr_accept;

    // Writes stop once full; a clear in the same cycle wins
    assign wr_accept = wr_i.en && !full_q && !clear_i;

    // Fill pointer wraps to zero as the last slot is written
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fill_ptr_q <= '0;
            full_q     <= 1'b0;
        end else if (clear_i) begin
            fill_ptr_q <= '0;
            full_q     <= 1'b0;
        end else if (wr_accept) begin
            fill_ptr_q <= fill_ptr_q + 1'b1;
            if (fill_ptr_q == addr_t'(MS_DEPTH - 1)) begin
                full_q <= 1'b1;
            end
        end
    end

    // Element array, row-major order
    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            mem_q[fill_ptr_q] <= wr_i.data;
        end
    end

    // Registered read, data one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

    assign full_o = full_q;

endmodule

// ==== verilog/block_sequencer.sv ====
`timescale 1ns/1ps

module block_sequencer (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 start_i,
    input  logic                 a_full_i,
    input  logic                 b_full_i,
    output mesh_pkg::addr_t      a_rd_addr_o,
    output mesh_pkg::addr_t      b_rd_addr_o,
    output logic                 rd_en_o,
    output mesh_pkg::pair_meta_t meta_o,
    output logic                 busy_o
);

    import mesh_pkg::*;

    localparam int CNT_W = $clog2(MS_PRODUCTS);

    seq_state_t state_q;
    seq_state_t state_d;

    // i, j: output tile; k: inner tile; r, c: C element; m: reduction element
    tile_idx_t i_q;
    tile_idx_t j_q;
    tile_idx_t k_q;
    elem_idx_t r_q;
    elem_idx_t c_q;
    elem_idx_t m_q;

    logic [CNT_W-1:0] issue_cnt_q;

    logic       start_ok;
    logic       issuing;
    logic       first_issue;
    logic       last_issue;
    addr_t      c_addr;
    pair_meta_t meta_q;

    function automatic int unsigned glob_idx(input tile_idx_t tile, input elem_idx_t elem);
        return tile * MS_T + elem;
    endfunction

    function automatic addr_t rc_addr(input int unsigned row, input int unsigned col);
        return addr_t'(row * MS_N + col);
    endfunction

    assign start_ok    = (state_q == SEQ_IDLE) && start_i && a_full_i && b_full_i;
    assign issuing     = (state_q == SEQ_ISSUE);
    assign first_issue = issuing && (issue_cnt_q == '0);
    assign last_issue  = issuing && (issue_cnt_q == CNT_W'(MS_PRODUCTS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (start_ok) begin
                    state_d = SEQ_ISSUE;
                end
            end
            SEQ_ISSUE: begin
                if (last_issue) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Nested index chain, m steps fastest, i slowest
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            issue_cnt_q <= '0;
            {i_q, j_q, k_q} <= '0;
            {r_q, c_q, m_q} <= '0;
        end else if (start_ok) begin
            issue_cnt_q <= '0;
            {i_q, j_q, k_q} <= '0;
            {r_q, c_q, m_q} <= '0;
        end else if (issuing) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
            if (m_q == elem_idx_t'(MS_T - 1)) begin
                m_q <= '0;
                if (c_q == elem_idx_t'(MS_T - 1)) begin
                    c_q <= '0;
                    if (r_q == elem_idx_t'(MS_T - 1)) begin
                        r_q <= '0;
                        if (k_q == tile_idx_t'(MS_TILES - 1)) begin
                            k_q <= '0;
                            if (j_q == tile_idx_t'(MS_TILES - 1)) begin
                                j_q <= '0;
                                i_q <= (i_q == tile_idx_t'(MS_TILES - 1)) ? '0 : i_q + 1'b1;
                            end else begin
                                j_q <= j_q + 1'b1;
                            end
                        end else begin
                            k_q <= k_q + 1'b1;
                        end
                    end else begin
                        r_q <= r_q + 1'b1;
                    end
                end else begin
                    c_q <= c_q + 1'b1;
                end
            end else begin
                m_q <= m_q + 1'b1;
            end
        end
    end

    // A[i*T+r][k*T+m] times B[k*T+m][j*T+c] feeds C[i*T+r][j*T+c]
    assign a_rd_addr_o = rc_addr(glob_idx(i_q, r_q), glob_idx(k_q, m_q));
    assign b_rd_addr_o = rc_addr(glob_idx(k_q, m_q), glob_idx(j_q, c_q));
    assign c_addr      = rc_addr(glob_idx(i_q, r_q), glob_idx(j_q, c_q));

    // Metadata lags the issue by one cycle to line up with store data
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            meta_q <= '0;
        end else begin
            meta_q.valid  <= issuing;
            meta_q.first  <= first_issue;
            meta_q.last   <= last_issue;
            meta_q.c_addr <= c_addr;
        end
    end

    assign rd_en_o = issuing;
    assign meta_o  = meta_q;
    assign busy_o  = issuing;

endmodule

// ==== verilog/tile_accumulator.sv ====
`timescale 1ns/1ps

module tile_accumulator (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  mesh_pkg::pair_meta_t meta_i,
    input  mesh_pkg::elem_t      a_i,
    input  mesh_pkg::elem_t      b_i,
    input  mesh_pkg::addr_t      c_rd_addr_i,
    output mesh_pkg::acc_t       c_rd_data_o,
    output logic                 done_o
);

    import mesh_pkg::*;

    acc_t c_mem_q [MS_DEPTH];

    acc_t product;
    acc_t c_rd_q;
    logic done_q;

    // Unsigned product, widened before the multiply
    assign product = acc_t'(a_i) * acc_t'(b_i);

    // C entries start at zero after reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int e = 0; e < MS_DEPTH; e++) begin
                c_mem_q[e] <= '0;
            end
        end else if (meta_i.valid) begin
            if (meta_i.first) begin
                // New run, old results are dropped
                for (int e = 0; e < MS_DEPTH; e++) begin
                    c_mem_q[e] <= '0;
                end
                c_mem_q[meta_i.c_addr] <= product;
            end else begin
                c_mem_q[meta_i.c_addr] <= c_mem_q[meta_i.c_addr] + product;
            end
        end
    end

    // Done drops on the first pair and rises with the last one
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_q <= 1'b0;
        end else if (meta_i.valid) begin
            if (meta_i.last) begin
                done_q <= 1'b1;
            end else if (meta_i.first) begin
                done_q <= 1'b0;
            end
        end
    end

    // Registered C read port
    always_ff @(posedge clk_i) begin
        c_rd_q <= c_mem_q[c_rd_addr_i];
    end

    assign c_rd_data_o = c_rd_q;
    assign done_o      = done_q;

endmodule

// ==== verilog/block_matmul.sv ====
`timescale 1ns/1ps

module block_matmul (
    input  logic               clk_i,
    input  logic               rstn_i,

    // Matrix loading
    input  mesh_pkg::wr_port_t a_wr_i,
    input  mesh_pkg::wr_port_t b_wr_i,
    input  logic               clear_i,
    output logic               a_full_o,
    output logic               b_full_o,

    // Run control
    input  logic               start_i,
    output logic               busy_o,
    output logic               done_o,

    // Result read port
    input  mesh_pkg::addr_t    c_rd_addr_i,
    output mesh_pkg::acc_t     c_rd_data_o
);

    import mesh_pkg::*;

    addr_t      a_rd_addr;
    addr_t      b_rd_addr;
    logic       rd_en;
    elem_t      a_rd_data;
    elem_t      b_rd_data;
    pair_meta_t meta;

    // Store for A
    matrix_store a_store (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .clear_i   (clear_i),
        .wr_i      (a_wr_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (a_rd_addr),
        .rd_data_o (a_rd_data),
        .full_o    (a_full_o)
    );

    // Store for B
    matrix_store b_store (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .clear_i   (clear_i),
        .wr_i      (b_wr_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (b_rd_addr),
        .rd_data_o (b_rd_data),
        .full_o    (b_full_o)
    );

    // Producer: walks i, j, k and the tile elements
    block_sequencer block_sequencer_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .start_i     (start_i),
        .a_full_i    (a_full_o),
        .b_full_i    (b_full_o),
        .a_rd_addr_o (a_rd_addr),
        .b_rd_addr_o (b_rd_addr),
        .rd_en_o     (rd_en),
        .meta_o      (meta),
        .busy_o      (busy_o)
    );

    // Consumer: sums the pairs into C
    tile_accumulator tile_accumulator_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .meta_i      (meta),
        .a_i         (a_rd_data),
        .b_i         (b_rd_data),
        .c_rd_addr_i (c_rd_addr_i),
        .c_rd_data_o (c_rd_data_o),
        .done_o      (done_o)
    );

endmodule

// ==== bench/block_matmul_tb.sv ====
`timescale 1ns/1ps
`include "mesh_cfg.svh"

module block_matmul_tb;

    import mesh_pkg::*;

    localparam int N     = `MS_MATRIX_SIZE;
    localparam int DW    = `MS_DATA_WIDTH;
    localparam int DEPTH = N * N;
    localparam int EXTRA = 2;
    localparam int RUNS  = 2;
    // Loading both stores, reading all of C, then about 70 cycles of run
    localparam int LOAD_CYCLES = 2 * (DEPTH + EXTRA) + 4;
    localparam int READ_CYCLES = DEPTH;
    localparam int LIMIT = RUNS * (LOAD_CYCLES + READ_CYCLES + 70) + 100;

    logic       clk_i = 1'b0;
    logic       rstn_i;
    wr_port_t   a_wr_i;
    wr_port_t   b_wr_i;
    logic       clear_i;
    logic       start_i;
    addr_t      c_rd_addr_i;
    logic       a_full_o;
    logic       b_full_o;
    logic       busy_o;
    logic       done_o;
    acc_t       c_rd_data_o;

    elem_t       mat_a [DEPTH];
    elem_t       mat_b [DEPTH];
    acc_t        gold [DEPTH];
    logic [31:0] lfsr_q;
    int          errors = 0;
    int          prop_errors = 0;
    int          cycle_cnt = 0;
    int          runs_done = 0;

    block_matmul block_matmul_inst (.*);

    always #5 clk_i = ~clk_i;

    // Done may only rise one edge after busy falls
    done_follows_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(done_o) |-> (!busy_o && !$past(busy_o) && $past(busy_o, 2)))
        else begin
            prop_errors++;
            $display("done_o rose without busy_o falling one cycle before");
        end

    // A full flag only drops after a clear
    full_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ($fell(a_full_o) || $fell(b_full_o)) |-> $past(clear_i))
        else begin
            prop_errors++;
            $display("A full flag dropped without a clear");
        end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= LIMIT) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic elem_t rand_elem();
        elem_t v;
        v = '0;
        for (int b = 0; b < DW; b++) begin
            v = {v[DW-2:0], next_bit()};
        end
        return v;
    endfunction

    function automatic void compute_golden();
        acc_t sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = '0;
                for (int m = 0; m < N; m++) begin
                    sum = sum + acc_t'(mat_a[r*N+m]) * acc_t'(mat_b[m*N+c]);
                end
                gold[r*N+c] = sum;
            end
        end
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic write_elem(input logic to_b, input elem_t data);
        if (to_b) begin
            b_wr_i.en   = 1'b1;
            b_wr_i.data = data;
        end else begin
            a_wr_i.en   = 1'b1;
            a_wr_i.data = data;
        end
        @(negedge clk_i);
        a_wr_i = '0;
        b_wr_i = '0;
    endtask

    task automatic load_range(input logic to_b, input int first, input int count);
        for (int n = first; n < first + count; n++) begin
            write_elem(to_b, to_b ? mat_b[n] : mat_a[n]);
            expect_equal(to_b ? "b_full_o" : "a_full_o", to_b ? b_full_o : a_full_o,
                         n == DEPTH - 1);
        end
    endtask

    // Junk writes into a full store
    task automatic write_extra(input logic to_b);
        for (int n = 0; n < EXTRA; n++) begin
            write_elem(to_b, rand_elem());
            expect_equal(to_b ? "b_full_o" : "a_full_o", to_b ? b_full_o : a_full_o, 1);
        end
    endtask

    task automatic start_not_full();
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        expect_equal("busy_o", busy_o, 0);
        @(negedge clk_i);
        expect_equal("busy_o", busy_o, 0);
    endtask

    task automatic run_matmul();
        int   busy_cycles;
        logic done_before;
        busy_cycles = 0;
        // Done stays high from the previous run until the first pair lands
        done_before = (runs_done > 0);
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        while (busy_o) begin
            busy_cycles++;
            expect_equal("done_o", done_o, (busy_cycles <= 2) ? done_before : 1'b0);
            // Second start while busy must not stretch the run
            start_i = (busy_cycles == 10);
            @(negedge clk_i);
        end
        start_i = 1'b0;
        expect_equal("busy_o cycles", busy_cycles, 64);
        expect_equal("done_o", done_o, 0);
        @(negedge clk_i);
        expect_equal("done_o", done_o, 1);
        runs_done++;
    endtask

    task automatic check_c_all(input logic expect_zero);
        for (int e = 0; e < DEPTH; e++) begin
            c_rd_addr_i = addr_t'(e);
            @(negedge clk_i);
            expect_equal($sformatf("c_rd_data_o[%0d]", e), c_rd_data_o,
                         expect_zero ? '0 : gold[e]);
        end
    endtask

    initial begin
        rstn_i      = 1'b0;
        a_wr_i      = '0;
        b_wr_i      = '0;
        clear_i     = 1'b0;
        start_i     = 1'b0;
        c_rd_addr_i = '0;
        lfsr_q      = 32'h4ff;
        repeat (8) @(negedge clk_i);
        rstn_i = 1'b1;

        expect_equal("busy_o", busy_o, 0);
        expect_equal("done_o", done_o, 0);
        expect_equal("a_full_o", a_full_o, 0);
        expect_equal("b_full_o", b_full_o, 0);
        check_c_all(1'b1);

        // First run, B left one short to try an early start
        for (int n = 0; n < DEPTH; n++) begin
            mat_a[n] = rand_elem();
            mat_b[n] = rand_elem();
        end
        compute_golden();
        load_range(1'b0, 0, DEPTH);
        write_extra(1'b0);
        load_range(1'b1, 0, DEPTH - 1);
        start_not_full();
        load_range(1'b1, DEPTH - 1, 1);
        write_extra(1'b1);
        run_matmul();
        check_c_all(1'b0);

        // Second run after a clear, with fresh data
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
        expect_equal("a_full_o", a_full_o, 0);
        expect_equal("b_full_o", b_full_o, 0);
        start_not_full();
        for (int n = 0; n < DEPTH; n++) begin
            mat_a[n] = rand_elem();
            mat_b[n] = rand_elem();
        end
        compute_golden();
        load_range(1'b0, 0, DEPTH);
        write_extra(1'b0);
        load_range(1'b1, 0, DEPTH);
        run_matmul();
        check_c_all(1'b0);

        $display("Check errors: %0d, property errors: %0d", errors, prop_errors);
        if (errors + prop_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== block_matmul.f ====
+incdir+verilog
verilog/mesh_pkg.sv
verilog/matrix_store.sv
verilog/block_sequencer.sv
verilog/tile_accumulator.sv
verilog/block_matmul.sv
bench/block_matmul_tb.sv

// ==== Bender.yml ====
package:
  name: block_matmul

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mesh_pkg.sv
      - verilog/matrix_store.sv
      - verilog/block_sequencer.sv
      - verilog/tile_accumulator.sv
      - verilog/block_matmul.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/block_matmul_tb.sv
